// ==== hw/core_pkg.sv ====
// Core package
// Widths, instruction field encodings and decoder enums shared by the
// RV32I pipeline stages
package core_pkg;

    localparam int XLEN       = 32;            // Data and address width
    localparam int REG_ADDR_W = 5;             // Register index width

    typedef logic [XLEN-1:0]       word_t;     // Data, PC or instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // Register index

    // ----------------------------------------------------------------------
    // funct3 / funct7 encodings
    // ----------------------------------------------------------------------
    localparam logic [2:0] F3_ADD  = 3'b000;   // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000; // Normal form
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

    // Major opcodes, valued by the ISA encoding
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_sltu, alu_pass_rhs
    } alu_op_t;

    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
    } br_op_t;

endpackage

// ==== hw/core_alu.sv ====
// Integer ALU
// Add, subtract, logic, shifts, set-less-than and pass-right
`timescale 1ns/1ps

module core_alu
    import core_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   lhs,
    input  word_t   rhs,
    output word_t   result
);

    logic [4:0] shamt;             // Shift amount from rhs

    assign shamt = rhs[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = lhs + rhs;
            alu_sub:  result = lhs - rhs;
            alu_and:  result = lhs & rhs;
            alu_or:   result = lhs | rhs;
            alu_xor:  result = lhs ^ rhs;
            alu_sll:  result = lhs << shamt;
            alu_srl:  result = lhs >> shamt;
            alu_sra:  result = word_t'($signed(lhs) >>> shamt);
            alu_slt:  result = {{(XLEN-1){1'b0}}, $signed(lhs) < $signed(rhs)};
            alu_sltu: result = {{(XLEN-1){1'b0}}, lhs < rhs};
            default:  result = rhs;    // LUI
        endcase
    end

endmodule

// ==== hw/core_regfile.sv ====
// General purpose register file
// 31 registers, two asynchronous reads and one synchronous write
`timescale 1ns/1ps

module core_regfile (
    input  logic        g_clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        rd_wen,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [1:31];      // No storage for x0

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (rd_wen && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

endmodule

// ==== hw/core_pipe_fetch.sv ====
// Fetch stage
// One outstanding aligned word request, a one-entry buffer towards
// decode, and the acknowledge side of the control-flow bus
`timescale 1ns/1ps

module core_pipe_fetch
    import core_pkg::*;
#(
    parameter word_t PC_RESET_ADDRESS = 32'h1000_0000
) (
    input  logic  g_clk,
    input  logic  rst,
    input  logic  cf_valid,
    input  word_t cf_target,
    input  logic  imem_gnt,
    input  word_t imem_rdata,
    input  logic  s1_ready,
    output logic  cf_ack,
    output logic  imem_req,
    output word_t imem_addr,
    output logic  s1_valid,
    output word_t s1_instr,
    output word_t s1_pc
);

    typedef enum logic {st_idle, st_wait} fetch_state_t;

    fetch_state_t state;
    word_t        fetch_pc;        // Address of the current or next request
    logic         buf_valid;       // Buffer holds a word for decode
    logic         resp;            // Word returning this cycle
    logic         buf_take;        // Decode takes the buffer
    logic         buf_free;        // Buffer empty by the next cycle

    assign resp     = (state == st_wait) && imem_gnt;
    assign buf_take = s1_valid && s1_ready;
    assign buf_free = !buf_valid || buf_take;

    // Nothing in flight, or the response arrives now and gets dropped
    assign cf_ack    = cf_valid && ((state == st_idle) || imem_gnt);
    assign imem_req  = (state == st_wait);
    assign imem_addr = fetch_pc;
    assign s1_valid  = buf_valid && !cf_valid; // No wrong-path issue

    always_ff @(posedge g_clk) begin
        if (rst) begin
            state     <= st_idle;
            fetch_pc  <= PC_RESET_ADDRESS;
            buf_valid <= 1'b0;
        end else if (cf_ack) begin
            state     <= st_wait;  // Restart at the target
            fetch_pc  <= cf_target;
            buf_valid <= 1'b0;
        end else if (resp) begin
            state     <= st_idle;  // Buffer refills, wait for decode
            fetch_pc  <= fetch_pc + 32'd4;
            buf_valid <= 1'b1;
        end else begin
            if (state == st_idle && buf_free) begin
                state <= st_wait;
            end
            if (buf_take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (resp) begin
            s1_instr <= imem_rdata;
            s1_pc    <= fetch_pc;
        end
    end

endmodule

// ==== hw/core_pipe_decode.sv ====
// Decode and operand gather
// Maps opcode and funct fields to ALU and branch operations, builds the
// immediate, forwards the writeback value and holds the result for execute
`timescale 1ns/1ps

module core_pipe_decode
    import core_pkg::*;
(
    input  logic      g_clk,
    input  logic      rst,
    input  logic      s1_valid,
    input  word_t     s1_instr,
    input  word_t     s1_pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      rd_wen,
    input  reg_addr_t rd_addr,
    input  word_t     rd_wdata,
    input  logic      s2_ready,
    output logic      s1_ready,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      s2_valid,
    output word_t     s2_pc,
    output word_t     s2_instr,
    output reg_addr_t s2_rd,
    output alu_op_t   s2_alu_op,
    output br_op_t    s2_br_op,
    output word_t     s2_lhs,
    output word_t     s2_rhs,
    output word_t     s2_rs1,
    output word_t     s2_rs2,
    output word_t     s2_imm
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;             // Supported encoding
    logic       writes_rd;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       hazard;            // Reads the rd held in s2
    alu_op_t    alu_op;
    br_op_t     br_op;
    word_t      imm;
    word_t      rs1_val;           // After forwarding
    word_t      rs2_val;

    assign opcode   = opcode_t'(s1_instr[6:0]);
    assign funct3   = s1_instr[14:12];
    assign funct7   = s1_instr[31:25];
    assign rs1_addr = s1_instr[19:15];
    assign rs2_addr = s1_instr[24:20];

    // ----------------------------------------------------------------------
    // Operation and immediate decode
    // ----------------------------------------------------------------------
    always_comb begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        alu_op    = alu_add;
        br_op     = br_none;
        imm       = {{20{s1_instr[31]}}, s1_instr[31:20]};  // I-type
        case (opcode)
            op_lui, op_auipc: begin
                imm      = {s1_instr[31:12], 12'b0};
                uses_rs1 = 1'b0;
                alu_op   = (opcode == op_lui) ? alu_pass_rhs : alu_add;
            end
            op_jal: begin
                imm      = {{12{s1_instr[31]}}, s1_instr[19:12], s1_instr[20],
                            s1_instr[30:21], 1'b0};
                uses_rs1 = 1'b0;
                br_op    = br_jal;
            end
            op_jalr: begin
                legal = (funct3 == 3'b000);
                br_op = br_jalr;
            end
            op_branch: begin
                imm       = {{20{s1_instr[31]}}, s1_instr[7], s1_instr[30:25],
                             s1_instr[11:8], 1'b0};
                writes_rd = 1'b0;
                uses_rs2  = 1'b1;
                case (funct3)
                    F3_BEQ:  br_op = br_eq;
                    F3_BNE:  br_op = br_ne;
                    F3_BLT:  br_op = br_lt;
                    F3_BGE:  br_op = br_ge;
                    F3_BLTU: br_op = br_ltu;
                    F3_BGEU: br_op = br_geu;
                    default: legal = 1'b0;
                endcase
            end
            op_imm, op_reg: begin
                uses_rs2 = (opcode == op_reg);
                case (funct3)
                    F3_ADD:  alu_op = (uses_rs2 && funct7 == F7_ALT) ? alu_sub : alu_add;
                    F3_SLL:  alu_op = alu_sll;
                    F3_SLT:  alu_op = alu_slt;
                    F3_SLTU: alu_op = alu_sltu;
                    F3_XOR:  alu_op = alu_xor;
                    F3_SR:   alu_op = (funct7 == F7_ALT) ? alu_sra : alu_srl;
                    F3_OR:   alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                if (uses_rs2) begin
                    // Only SUB and SRA take the alternate funct7
                    legal = (funct7 == F7_BASE) ||
                            (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
                end else if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == F3_SR) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end
            end
            default: legal = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Operand gather and interlock
    // ----------------------------------------------------------------------
    assign rs1_val = (rd_wen && rd_addr != '0 && rd_addr == rs1_addr) ? rd_wdata : rs1_data;
    assign rs2_val = (rd_wen && rd_addr != '0 && rd_addr == rs2_addr) ? rd_wdata : rs2_data;

    // Result of the s2 instruction is not yet visible to forwarding
    assign hazard = s2_valid && (s2_rd != '0) &&
                    ((uses_rs1 && s2_rd == rs1_addr) || (uses_rs2 && s2_rd == rs2_addr));

    assign s1_ready = (!s2_valid || s2_ready) && !hazard;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (!s2_valid || s2_ready) begin
            s2_valid <= s1_valid && s1_ready;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_valid && s1_ready) begin
            s2_pc     <= s1_pc;
            s2_instr  <= s1_instr;
            s2_rd     <= (legal && writes_rd) ? s1_instr[11:7] : '0; // Illegal writes nothing
            s2_alu_op <= alu_op;
            s2_br_op  <= legal ? br_op : br_none;
            s2_lhs    <= (opcode == op_auipc) ? s1_pc : rs1_val;
            s2_rhs    <= uses_rs2 ? rs2_val : imm;
            s2_rs1    <= rs1_val;
            s2_rs2    <= rs2_val;
            s2_imm    <= imm;
        end
    end

endmodule

// ==== hw/core_pipe_exec.sv ====
// Execute stage
// Resolves branches and jumps, raises control-flow changes and selects
// the value to write back
`timescale 1ns/1ps

module core_pipe_exec
    import core_pkg::*;
(
    input  logic      s2_valid,
    input  word_t     s2_pc,
    input  word_t     s2_instr,
    input  reg_addr_t s2_rd,
    input  alu_op_t   s2_alu_op,
    input  br_op_t    s2_br_op,
    input  word_t     s2_lhs,
    input  word_t     s2_rhs,
    input  word_t     s2_rs1,
    input  word_t     s2_rs2,
    input  word_t     s2_imm,
    input  logic      cf_ack,
    output logic      s2_ready,
    output logic      cf_valid,
    output word_t     cf_target,
    output logic      s3_valid,
    output word_t     s3_pc,
    output word_t     s3_instr,
    output reg_addr_t s3_rd,
    output word_t     s3_wdata
);

    word_t alu_result;
    word_t jalr_sum;               // rs1 plus immediate
    logic  taken;
    logic  is_jump;

    core_alu u_alu (
        .alu_op (s2_alu_op),
        .lhs    (s2_lhs),
        .rhs    (s2_rhs),
        .result (alu_result)
    );

    always_comb begin
        case (s2_br_op)
            br_eq:            taken = (s2_rs1 == s2_rs2);
            br_ne:            taken = (s2_rs1 != s2_rs2);
            br_lt:            taken = ($signed(s2_rs1) <  $signed(s2_rs2));
            br_ge:            taken = ($signed(s2_rs1) >= $signed(s2_rs2));
            br_ltu:           taken = (s2_rs1 <  s2_rs2);
            br_geu:           taken = (s2_rs1 >= s2_rs2);
            br_jal, br_jalr:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign is_jump  = (s2_br_op == br_jal) || (s2_br_op == br_jalr);
    assign jalr_sum = s2_rs1 + s2_imm;

    assign cf_valid  = s2_valid && taken;
    assign cf_target = (s2_br_op == br_jalr) ? {jalr_sum[XLEN-1:1], 1'b0}
                                             : s2_pc + s2_imm;

    // Hold the instruction until fetch takes the redirect
    assign s2_ready = !cf_valid || cf_ack;

    assign s3_valid = s2_valid && s2_ready;
    assign s3_pc    = s2_pc;
    assign s3_instr = s2_instr;
    assign s3_rd    = s2_rd;
    assign s3_wdata = (s2_rd == '0) ? '0 :          // Nothing written
                      is_jump       ? s2_pc + 32'd4 : // Link address
                                      alu_result;

endmodule

// ==== hw/core_pipe_wb.sv ====
// Writeback stage
// Registers retiring instructions, writes the register file, feeds the
// forwarding path and drives the retirement trace
`timescale 1ns/1ps

module core_pipe_wb
    import core_pkg::*;
(
    input  logic      g_clk,
    input  logic      rst,
    input  logic      s3_valid,
    input  word_t     s3_pc,
    input  word_t     s3_instr,
    input  reg_addr_t s3_rd,
    input  word_t     s3_wdata,
    output logic      rd_wen,
    output reg_addr_t rd_addr,
    output word_t     rd_wdata,
    output logic      trs_valid,
    output word_t     trs_pc,
    output word_t     trs_instr,
    output reg_addr_t trs_rd,
    output word_t     trs_wdata
);

    always_ff @(posedge g_clk) begin
        if (rst) begin
            trs_valid <= 1'b0;
        end else begin
            trs_valid <= s3_valid; // Never stalls
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid) begin
            trs_pc    <= s3_pc;
            trs_instr <= s3_instr;
            trs_rd    <= s3_rd;
            trs_wdata <= s3_wdata;
        end
    end

    assign rd_wen   = trs_valid && (trs_rd != '0);
    assign rd_addr  = trs_rd;
    assign rd_wdata = trs_wdata;

endmodule

// ==== hw/core_top.sv ====
// Core top level
// In-order RV32I pipeline: fetch, decode, execute and writeback stages
// around a 2R1W register file, with one shared control-flow change bus
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
#(
    parameter word_t PC_RESET_ADDRESS = 32'h1000_0000 // First fetch address
) (
    input  logic      g_clk,
    input  logic      rst,
    input  logic      imem_gnt,    // Fetch response valid
    input  word_t     imem_rdata,  // Fetch response word
    output logic      imem_req,    // Fetch request
    output word_t     imem_addr,   // Fetch address
    output logic      trs_valid,   // Instruction retired
    output word_t     trs_pc,
    output word_t     trs_instr,
    output reg_addr_t trs_rd,      // Zero when nothing written
    output word_t     trs_wdata
);

    // ----------------------------------------------------------------------
    // Control-flow change bus
    // ----------------------------------------------------------------------
    logic      cf_valid;           // Execute wants a redirect
    logic      cf_ack;             // Fetch took the redirect
    word_t     cf_target;          // Redirect destination

    // ----------------------------------------------------------------------
    // Stage wiring
    // ----------------------------------------------------------------------
    logic      s1_valid;           // Fetch -> decode
    logic      s1_ready;
    word_t     s1_instr;
    word_t     s1_pc;

    reg_addr_t rs1_addr;           // Register file read ports
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      s2_valid;           // Decode -> execute
    logic      s2_ready;
    word_t     s2_pc;
    word_t     s2_instr;
    reg_addr_t s2_rd;
    alu_op_t   s2_alu_op;
    br_op_t    s2_br_op;
    word_t     s2_lhs;             // ALU operands
    word_t     s2_rhs;
    word_t     s2_rs1;             // Branch compare and JALR base
    word_t     s2_rs2;
    word_t     s2_imm;

    logic      s3_valid;           // Execute -> writeback, no stall
    word_t     s3_pc;
    word_t     s3_instr;
    reg_addr_t s3_rd;
    word_t     s3_wdata;

    logic      rd_wen;             // Register write, also forwarding source
    reg_addr_t rd_addr;
    word_t     rd_wdata;

    // Port names line up across the stages, so connect by name
    core_pipe_fetch #(
        .PC_RESET_ADDRESS(PC_RESET_ADDRESS)
    ) u_fetch (.*);

    core_pipe_decode u_decode (.*);

    core_pipe_exec u_exec (.*);

    core_regfile u_regfile (.*);

    core_pipe_wb u_wb (.*);

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
// Free-running clock and a reset held for the first two rising edges
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 40          // Clock period in ns
) (
    output logic g_clk,
    output logic rst
);

    initial begin
        g_clk = 1'b0;
        forever #(PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge g_clk);
        #1 rst = 1'b0;                 // Released just after the edge
    end

endmodule

// ==== tests/core_top_sva.sv ====
// Fetch port and control-flow bus checks
// Bound into the fetch stage, which sees the memory port and the bus
`timescale 1ns/1ps

module core_top_sva
    import core_pkg::*;
(
    input logic  g_clk,
    input logic  rst,
    input logic  imem_req,
    input logic  imem_gnt,
    input word_t imem_addr,
    input logic  cf_valid,
    input logic  cf_ack,
    input word_t cf_target,
    input logic  s1_valid
);

    // Request and its address stay put until granted
    property req_addr_hold;
        @(posedge g_clk) disable iff (rst)
        imem_req && !imem_gnt |=> imem_req && $stable(imem_addr);
    endproperty

    // Redirect held until fetch acknowledges it
    property cf_hold;
        @(posedge g_clk) disable iff (rst)
        cf_valid && !cf_ack |=> cf_valid && $stable(cf_target);
    endproperty

    // Buffered wrong-path word is dropped by the acknowledge
    property no_issue_after_redirect;
        @(posedge g_clk) disable iff (rst)
        cf_ack |=> !s1_valid;
    endproperty

    assert property (req_addr_hold)
        else $error("imem_addr or imem_req changed before the grant");
    assert property (cf_hold)
        else $error("cf_valid or cf_target changed before cf_ack");
    assert property (no_issue_after_redirect)
        else $error("s1_valid high in the cycle after a redirect was taken");

endmodule

bind core_pipe_fetch core_top_sva u_sva (.*);

// ==== tests/tb_core_top.sv ====
// Core testbench
// Instruction memory model with random grant delays, retirement trace
// checking against the trace file, watchdog and result line
`timescale 1ns/1ps

module tb_core_top;
    import core_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          MEM_WORDS  = 64;             // Program window
    localparam int          MAX_RECS   = 64;
    localparam logic [31:0] PROG_BASE  = 32'h1000_0000;  // Reset PC too

    logic      g_clk;
    logic      rst;
    logic      imem_gnt;
    word_t     imem_rdata;
    logic      imem_req;
    word_t     imem_addr;
    logic      trs_valid;
    word_t     trs_pc;
    word_t     trs_instr;
    reg_addr_t trs_rd;
    word_t     trs_wdata;

    logic [31:0] mem_data   [0:MEM_WORDS-1];
    bit          mem_loaded [0:MEM_WORDS-1];  // Words outside are never granted
    logic [31:0] exp_pc     [0:MAX_RECS-1];
    logic [31:0] exp_instr  [0:MAX_RECS-1];
    logic [4:0]  exp_rd     [0:MAX_RECS-1];
    logic [31:0] exp_wdata  [0:MAX_RECS-1];

    int num_recs     = 0;
    int rec_idx      = 0;              // Next expected record
    int value_errors = 0;
    int order_errors = 0;
    int delay_left   = -1;             // Grant countdown, -1 when idle
    int seed         = 32'h0304_eedc;
    bit trace_ready  = 1'b0;

    tb_clock #(.PERIOD(CLK_PERIOD)) clk_gen (.g_clk(g_clk), .rst(rst));

    core_top #(.PC_RESET_ADDRESS(PROG_BASE)) dut (.*);

    // ----------------------------------------------------------------------
    // Trace file
    // ----------------------------------------------------------------------
    function automatic bit load_trace();
        int          fd;
        int          idx;
        string       line;
        logic [31:0] addr;
        logic [31:0] instr;
        logic [31:0] retires;
        logic [31:0] rd;
        logic [31:0] wdata;
        fd = $fopen("tests/core_trace.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h %h", addr, instr, retires, rd, wdata) == 5) begin
                idx = (addr - PROG_BASE) >> 2;
                mem_data[idx]   = instr;
                mem_loaded[idx] = 1'b1;
                if (retires != 0) begin      // Expected in file order
                    exp_pc[num_recs]    = addr;
                    exp_instr[num_recs] = instr;
                    exp_rd[num_recs]    = rd[4:0];
                    exp_wdata[num_recs] = wdata;
                    num_recs++;
                end
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    function automatic bit word_present(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - PROG_BASE;
        return (off[1:0] == 2'b00) && (off < MEM_WORDS * 4) && mem_loaded[off >> 2];
    endfunction

    // ----------------------------------------------------------------------
    // Instruction memory, 0 to 2 cycles per request
    // ----------------------------------------------------------------------
    initial begin
        imem_gnt   = 1'b0;
        imem_rdata = '0;
        forever begin
            @(posedge g_clk);
            #1;
            imem_gnt = 1'b0;
            if (rst || !imem_req) begin
                delay_left = -1;
            end else begin
                if (delay_left < 0) begin
                    delay_left = $unsigned($random(seed)) % 3;  // New request
                end
                if (delay_left > 0) begin
                    delay_left--;
                end else if (word_present(imem_addr)) begin
                    imem_gnt   = 1'b1;
                    imem_rdata = mem_data[(imem_addr - PROG_BASE) >> 2];
                    delay_left = -1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Retirement checking, sampled mid-cycle
    // ----------------------------------------------------------------------
    task automatic check_retirement();
        assert (rec_idx < num_recs) else begin
            $display("Retirement beyond the end of the trace at pc %h", trs_pc);
            order_errors++;
            return;
        end
        assert (trs_pc == exp_pc[rec_idx]) else begin
            $display("ERROR trs_pc got %h expected %h", trs_pc, exp_pc[rec_idx]);
            value_errors++;
        end
        assert (trs_instr == exp_instr[rec_idx]) else begin
            $display("ERROR trs_instr got %h expected %h", trs_instr, exp_instr[rec_idx]);
            value_errors++;
        end
        assert (trs_rd == exp_rd[rec_idx]) else begin
            $display("ERROR trs_rd got %h expected %h", trs_rd, exp_rd[rec_idx]);
            value_errors++;
        end
        assert (trs_wdata == exp_wdata[rec_idx]) else begin
            $display("ERROR trs_wdata got %h expected %h", trs_wdata, exp_wdata[rec_idx]);
            value_errors++;
        end
        rec_idx++;
    endtask

    always @(negedge g_clk) begin
        if (!rst && trs_valid) begin
            check_retirement();
        end
    end

    task automatic print_summary();
        $display("Retired %0d of %0d records, %0d value errors, %0d order errors",
                 rec_idx, num_recs, value_errors, order_errors);
    endtask

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------
    initial begin
        if (!load_trace()) begin
            $display("Could not open the trace file tests/core_trace.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            trace_ready = 1'b1;
            wait (rec_idx >= num_recs);
            repeat (10) @(posedge g_clk);  // Window for extra retirements
            print_summary();
            if (value_errors == 0 && order_errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    initial begin
        wait (trace_ready);
        #(num_recs * 20 * CLK_PERIOD); // 20 cycles per record
        $display("Timeout with %0d retirements still missing", num_recs - rec_idx);
        print_summary();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/core_trace.txt ====
// addr instr retires rd wdata, all hex; retires 1 = expected record in file order
// retires 0 = wrong-path or jumped-over word that must never retire
10000000 123450b7 1 01 12345000
10000004 ffb00113 1 02 fffffffb
10000008 67808193 1 03 12345678
1000000c 00218233 1 04 12345673
10000010 403202b3 1 05 fffffffb
10000014 0011c333 1 06 00000678
10000018 001363b3 1 07 12345678
1000001c 0f01f413 1 08 00000070
10000020 00441493 1 09 00000700
10000024 40115513 1 0a fffffffd
10000028 0082d5b3 1 0b 0000ffff
1000002c 00b12633 1 0c 00000001
10000030 00b136b3 1 0d 00000000
10000034 00001717 1 0e 10001034
10000038 00108013 1 00 00000000
1000003c 023100b3 1 00 00000000
10000040 00008793 1 0f 12345000
10000044 00510463 1 00 00000000
10000048 7ff00813 0 00 00000000
1000004c 0025c463 1 00 00000000
10000050 0025e463 1 00 00000000
10000054 00100813 0 00 00000000
10000058 00c008ef 1 11 1000005c
1000005c 00200813 0 00 00000000
10000060 00300813 0 00 00000000
10000064 01188967 1 12 10000068
10000068 00400813 0 00 00000000
1000006c 00d15463 1 00 00000000
10000070 00d17463 1 00 00000000
10000074 00500813 0 00 00000000
10000078 00d61463 1 00 00000000
1000007c 00600813 0 00 00000000
10000080 011909b3 1 13 200000c4
10000084 4082da33 1 14 ffffffff
10000088 00ca1ab3 1 15 fffffffe
1000008c fffacb13 1 16 00000001
10000090 002b2b93 1 17 00000001

// ==== verilog.f ====
hw/core_pkg.sv
hw/core_alu.sv
hw/core_regfile.sv
hw/core_pipe_fetch.sv
hw/core_pipe_decode.sv
hw/core_pipe_exec.sv
hw/core_pipe_wb.sv
hw/core_top.sv
tests/tb_clock.sv
tests/core_top_sva.sv
tests/tb_core_top.sv
